// File: rtl/div_pkg.sv
`default_nettype none

package div_pkg;

  // operand width and counter width
  localparam int unsigned div_width = 32;
  localparam int unsigned clz_width = 6;

  // steps for a dividend with no leading zeros
  localparam logic [clz_width-1:0] steps_full = clz_width'(div_width + 1);

  // register byte offsets
  localparam logic [7:0] addr_dividend  = 8'h00;
  localparam logic [7:0] addr_divisor   = 8'h04;
  localparam logic [7:0] addr_ctrl      = 8'h08;
  localparam logic [7:0] addr_status    = 8'h0C;
  localparam logic [7:0] addr_quotient  = 8'h10;
  localparam logic [7:0] addr_remainder = 8'h14;

  // CTRL bit positions
  localparam int unsigned ctrl_start_bit  = 0;
  localparam int unsigned ctrl_signed_bit = 1;
  localparam int unsigned ctrl_abort_bit  = 2;

  typedef struct packed {
    logic [div_width-1:0] dividend;
    logic [div_width-1:0] divisor;
    logic                 is_signed;
  } div_req_t;

  // magnitudes plus the signs still to apply
  typedef struct packed {
    logic [div_width-1:0] quotient;
    logic [div_width-1:0] remainder;
    logic                 q_neg;
    logic                 r_neg;
    logic                 reused;
  } div_raw_t;

endpackage

`default_nettype wire

// File: rtl/div_clz.sv
`timescale 1ns/1ps
`default_nettype none

module div_clz (
  input  logic [div_pkg::div_width-1:0] value,
  output logic [div_pkg::clz_width-1:0] count
);

  // leaf 0 holds the most significant pair
  logic [1:0] c2  [16];
  logic [2:0] c4  [8];
  logic [3:0] c8  [4];
  logic [4:0] c16 [2];

  for (genvar i = 0; i < 16; i++) begin : g_leaf
    assign c2[i] = value[31-2*i] ? 2'd0 : (value[30-2*i] ? 2'd1 : 2'd2);
  end

  // upper half all zero, so add the lower half
  for (genvar i = 0; i < 8; i++) begin : g_l4
    assign c4[i] = c2[2*i][1] ? 3'd2 + c2[2*i+1] : {1'b0, c2[2*i]};
  end

  for (genvar i = 0; i < 4; i++) begin : g_l8
    assign c8[i] = c4[2*i][2] ? 4'd4 + c4[2*i+1] : {1'b0, c4[2*i]};
  end

  for (genvar i = 0; i < 2; i++) begin : g_l16
    assign c16[i] = c8[2*i][3] ? 5'd8 + c8[2*i+1] : {1'b0, c8[2*i]};
  end

  assign count = c16[0][4] ? 6'd16 + c16[1] : {1'b0, c16[0]};

endmodule

`default_nettype wire

// File: rtl/div_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module div_apb_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [7:0]                    paddr,
  input  logic [div_pkg::div_width-1:0] pwdata,
  input  logic [div_pkg::div_width-1:0] quotient,
  input  logic [div_pkg::div_width-1:0] remainder,
  input  logic                          done,
  input  logic                          reused,
  input  logic                          busy,
  output logic [div_pkg::div_width-1:0] prdata,
  output logic                          pready,
  output logic                          pslverr,
  output div_pkg::div_req_t             req,
  output logic                          req_valid,
  output logic                          flush,
  output logic                          rd_remainder
);

  logic                          access;
  logic                          wr;
  logic                          mapped;
  logic                          ctrl_wr;
  logic                          start_wr;
  logic                          abort_wr;
  logic                          start_err;
  logic [div_pkg::div_width-1:0] dividend_q;
  logic [div_pkg::div_width-1:0] divisor_q;
  logic                          signed_q;
  logic [div_pkg::div_width-1:0] ctrl_rd;
  logic [div_pkg::div_width-1:0] status_rd;

  // no wait states
  assign pready = 1'b1;

  assign access   = psel & penable;
  assign wr       = access & pwrite;
  assign ctrl_wr  = wr & (paddr == div_pkg::addr_ctrl);
  assign abort_wr = ctrl_wr & pwdata[div_pkg::ctrl_abort_bit];
  assign start_wr = ctrl_wr & pwdata[div_pkg::ctrl_start_bit] & ~pwdata[div_pkg::ctrl_abort_bit];

  // start while a division or an unread result is pending
  assign start_err = start_wr & busy;
  assign pslverr   = access & (~mapped | start_err);

  assign rd_remainder = access & ~pwrite & (paddr == div_pkg::addr_remainder);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dividend_q <= '0;
      divisor_q  <= '0;
      signed_q   <= 1'b0;
    end else begin
      if (wr && paddr == div_pkg::addr_dividend) begin
        dividend_q <= pwdata;
      end
      if (wr && paddr == div_pkg::addr_divisor) begin
        divisor_q <= pwdata;
      end
      if (ctrl_wr && !start_err) begin
        signed_q <= pwdata[div_pkg::ctrl_signed_bit];
      end
    end
  end

  // issue and abort pulses
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
      flush     <= 1'b0;
    end else begin
      req_valid <= start_wr & ~busy;
      flush     <= abort_wr;
    end
  end

  assign req = '{dividend: dividend_q, divisor: divisor_q, is_signed: signed_q};

  always_comb begin
    ctrl_rd = '0;
    ctrl_rd[div_pkg::ctrl_signed_bit] = signed_q;
  end

  assign status_rd = {{(div_pkg::div_width-3){1'b0}}, reused, done, busy};

  always_comb begin
    mapped = 1'b1;
    case (paddr)
      div_pkg::addr_dividend:  prdata = dividend_q;
      div_pkg::addr_divisor:   prdata = divisor_q;
      div_pkg::addr_ctrl:      prdata = ctrl_rd;
      div_pkg::addr_status:    prdata = status_rd;
      div_pkg::addr_quotient:  prdata = quotient;
      div_pkg::addr_remainder: prdata = remainder;
      default: begin
        prdata = '0;
        mapped = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/div_iter_unit.sv
`timescale 1ns/1ps
`default_nettype none

module div_iter_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  div_pkg::div_req_t req,
  input  logic              req_valid,
  input  logic              flush,
  input  logic              raw_ready,
  output div_pkg::div_raw_t raw,
  output logic              raw_valid,
  output logic              busy_core
);

  typedef enum logic [1:0] {st_idle, st_work, st_out} state_t;

  state_t                        state;
  logic                          dvd_neg;
  logic                          dvs_neg;
  logic [div_pkg::div_width-1:0] dvd_mag;
  logic [div_pkg::div_width-1:0] dvs_mag;
  logic                          div_zero;
  logic                          overflow;
  logic                          same_ops;
  logic [div_pkg::clz_width-1:0] clz_cnt;
  logic [div_pkg::clz_width-1:0] first_cnt;

  // held operands and results, also used for reuse
  logic [div_pkg::div_width-1:0] dvd_q;
  logic [div_pkg::div_width-1:0] dvs_q;
  logic [div_pkg::div_width-1:0] quot_q;
  logic [div_pkg::div_width-1:0] rem_q;
  logic [div_pkg::clz_width-1:0] cnt_q;
  logic                          q_neg_q;
  logic                          r_neg_q;
  logic                          reused_q;

  logic [div_pkg::div_width-1:0] quot_s [3];
  logic [div_pkg::div_width-1:0] rem_s  [3];
  logic [div_pkg::div_width-1:0] quot_nxt;
  logic [div_pkg::div_width-1:0] rem_nxt;
  logic [div_pkg::clz_width-1:0] cnt_nxt;

  assign dvd_neg = req.is_signed & req.dividend[div_pkg::div_width-1];
  assign dvs_neg = req.is_signed & req.divisor[div_pkg::div_width-1];
  assign dvd_mag = dvd_neg ? -req.dividend : req.dividend;
  assign dvs_mag = dvs_neg ? -req.divisor : req.divisor;

  assign div_zero = (req.divisor == '0);
  // most negative value over minus one
  assign overflow = req.is_signed & (req.divisor == '1) &
                    (req.dividend == {1'b1, {(div_pkg::div_width-1){1'b0}}});
  assign same_ops = (dvd_mag == dvd_q) & (dvs_mag == dvs_q) &
                    ((dvd_neg ^ dvs_neg) == q_neg_q) & (dvd_neg == r_neg_q);

  div_clz clz_i (
    .value (dvd_mag),
    .count (clz_cnt)
  );

  assign first_cnt = div_pkg::steps_full - clz_cnt;

  // one restoring step
  function automatic void div_step(
    input  logic [div_pkg::div_width-1:0] rem_in,
    input  logic [div_pkg::div_width-1:0] quot_in,
    input  logic [div_pkg::div_width-1:0] dvs,
    output logic [div_pkg::div_width-1:0] rem_out,
    output logic [div_pkg::div_width-1:0] quot_out
  );
    logic [div_pkg::div_width:0] shifted;
    logic                        fits;
    shifted  = {rem_in, quot_in[div_pkg::div_width-1]};
    fits     = (shifted >= {1'b0, dvs});
    rem_out  = fits ? shifted[div_pkg::div_width-1:0] - dvs : shifted[div_pkg::div_width-1:0];
    quot_out = {quot_in[div_pkg::div_width-2:0], fits};
  endfunction

  always_comb begin
    div_step(rem_q, quot_q, dvs_q, rem_s[0], quot_s[0]);
    div_step(rem_s[0], quot_s[0], dvs_q, rem_s[1], quot_s[1]);
    div_step(rem_s[1], quot_s[1], dvs_q, rem_s[2], quot_s[2]);
    // fewer than three steps left
    case (cnt_q)
      6'd2: begin
        quot_nxt = quot_s[0];
        rem_nxt  = rem_s[0];
        cnt_nxt  = 6'd1;
      end
      6'd3: begin
        quot_nxt = quot_s[1];
        rem_nxt  = rem_s[1];
        cnt_nxt  = 6'd1;
      end
      default: begin
        quot_nxt = quot_s[2];
        rem_nxt  = rem_s[2];
        cnt_nxt  = cnt_q - 6'd3;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      dvd_q    <= '0;
      dvs_q    <= '0;
      quot_q   <= '0;
      rem_q    <= '0;
      cnt_q    <= '0;
      q_neg_q  <= 1'b0;
      r_neg_q  <= 1'b0;
      reused_q <= 1'b0;
    end else if (flush) begin
      state    <= st_idle;
      dvd_q    <= '0;
      dvs_q    <= '0;
      quot_q   <= '0;
      rem_q    <= '0;
      cnt_q    <= '0;
      q_neg_q  <= 1'b0;
      r_neg_q  <= 1'b0;
      reused_q <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (req_valid) begin
            reused_q <= 1'b0;
            if (div_zero || overflow) begin
              // held operands zeroed so no later request matches
              dvd_q   <= '0;
              dvs_q   <= '0;
              quot_q  <= div_zero ? '1 : {1'b1, {(div_pkg::div_width-1){1'b0}}};
              rem_q   <= div_zero ? req.dividend : '0;
              q_neg_q <= 1'b0;
              r_neg_q <= 1'b0;
              state   <= st_out;
            end else if (same_ops) begin
              reused_q <= 1'b1;
              state    <= st_out;
            end else begin
              dvd_q   <= dvd_mag;
              dvs_q   <= dvs_mag;
              q_neg_q <= dvd_neg ^ dvs_neg;
              r_neg_q <= dvd_neg;
              quot_q  <= dvd_mag << clz_cnt;
              rem_q   <= '0;
              cnt_q   <= first_cnt;
              state   <= (first_cnt == 6'd1) ? st_out : st_work;
            end
          end
        end
        st_work: begin
          quot_q <= quot_nxt;
          rem_q  <= rem_nxt;
          cnt_q  <= cnt_nxt;
          if (cnt_nxt == 6'd1) begin
            state <= st_out;
          end
        end
        st_out: begin
          // stall here until the buffer is free
          if (raw_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign raw = '{quotient: quot_q, remainder: rem_q, q_neg: q_neg_q,
                 r_neg: r_neg_q, reused: reused_q};
  assign raw_valid = (state == st_out);
  assign busy_core = req_valid | (state != st_idle);

endmodule

`default_nettype wire

// File: rtl/div_result_buf.sv
`timescale 1ns/1ps
`default_nettype none

module div_result_buf (
  input  logic                          clk,
  input  logic                          rst_n,
  input  div_pkg::div_raw_t             raw,
  input  logic                          raw_valid,
  input  logic                          rd_remainder,
  input  logic                          busy_core,
  output logic                          raw_ready,
  output logic [div_pkg::div_width-1:0] quotient,
  output logic [div_pkg::div_width-1:0] remainder,
  output logic                          done,
  output logic                          reused,
  output logic                          busy
);

  logic                          take;
  logic [div_pkg::div_width-1:0] quot_fix;
  logic [div_pkg::div_width-1:0] rem_fix;

  // free until the remainder has been read
  assign raw_ready = ~done;
  assign take      = raw_valid & raw_ready;

  assign quot_fix = raw.q_neg ? -raw.quotient : raw.quotient;
  assign rem_fix  = raw.r_neg ? -raw.remainder : raw.remainder;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done   <= 1'b0;
      reused <= 1'b0;
    end else if (take) begin
      done   <= 1'b1;
      reused <= raw.reused;
    end else if (rd_remainder) begin
      done   <= 1'b0;
      reused <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      quotient  <= quot_fix;
      remainder <= rem_fix;
    end
  end

  // unread result keeps the unit busy
  assign busy = busy_core | done;

endmodule

`default_nettype wire

// File: rtl/div_top.sv
`timescale 1ns/1ps
`default_nettype none

module div_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [7:0]                    paddr,
  input  logic [div_pkg::div_width-1:0] pwdata,
  output logic [div_pkg::div_width-1:0] prdata,
  output logic                          pready,
  output logic                          pslverr
);

  div_pkg::div_req_t             req;
  logic                          req_valid;
  logic                          flush;
  logic                          rd_remainder;
  div_pkg::div_raw_t             raw;
  logic                          raw_valid;
  logic                          raw_ready;
  logic                          busy_core;
  logic [div_pkg::div_width-1:0] quotient;
  logic [div_pkg::div_width-1:0] remainder;
  logic                          done;
  logic                          reused;
  logic                          busy;

  div_apb_regs regs_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .quotient     (quotient),
    .remainder    (remainder),
    .done         (done),
    .reused       (reused),
    .busy         (busy),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .req          (req),
    .req_valid    (req_valid),
    .flush        (flush),
    .rd_remainder (rd_remainder)
  );

  div_iter_unit core_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_valid (req_valid),
    .flush     (flush),
    .raw_ready (raw_ready),
    .raw       (raw),
    .raw_valid (raw_valid),
    .busy_core (busy_core)
  );

  div_result_buf rbuf_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .raw          (raw),
    .raw_valid    (raw_valid),
    .rd_remainder (rd_remainder),
    .busy_core    (busy_core),
    .raw_ready    (raw_ready),
    .quotient     (quotient),
    .remainder    (remainder),
    .done         (done),
    .reused       (reused),
    .busy         (busy)
  );

endmodule

`default_nettype wire

// File: verification/div_properties.sv
`timescale 1ns/1ps
`default_nettype none

module div_properties (
  input logic              clk,
  input logic              rst_n,
  input logic              req_valid,
  input logic              flush,
  input logic              in_idle,
  input logic              raw_valid,
  input logic              raw_ready,
  input div_pkg::div_raw_t raw
);

  // requests only reach an idle core
  req_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid |-> in_idle)
    else $error("req_valid high while the core is not idle");

  // result held until the buffer takes it
  raw_held: assert property (@(posedge clk) disable iff (!rst_n)
    raw_valid && !raw_ready && !flush |=> raw_valid && $stable(raw))
    else $error("raw dropped or changed while raw_ready was low");

  accept_clean: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid |-> !flush && !raw_valid)
    else $error("flush or raw_valid in the same cycle as an accept");

endmodule

bind div_iter_unit div_properties props_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_valid (req_valid),
  .flush     (flush),
  .in_idle   (state == st_idle),
  .raw_valid (raw_valid),
  .raw_ready (raw_ready),
  .raw       (raw)
);

`default_nettype wire

// File: verification/div_tb.sv
`timescale 1ns/1ps
`default_nettype none

module div_tb;

  // operands, signedness and expected results of one division
  typedef struct packed {
    logic [31:0] dividend;
    logic [31:0] divisor;
    logic        is_signed;
    logic [31:0] quotient;
    logic [31:0] remainder;
    logic        reused;
  } row_t;

  localparam int n_rows   = 17;
  localparam int n_random = 40;
  // table, random pairs, abort, back-pressure, unmapped
  localparam int cycle_limit = 200 * (n_rows + n_random + 4);

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  row_t        rows [n_rows];
  int          error_count;
  int          cycle_count;

  div_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run did not complete within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    error_count++;
    $display("ERR t=%0t %s expected %08h actual %08h", $time, name, expected, actual);
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("FAIL t=%0t %s", $time, what);
  endtask

  function automatic logic [31:0] ctrl_word(input logic start, input logic sgn,
                                            input logic abort);
    logic [31:0] w;
    w = '0;
    w[div_pkg::ctrl_start_bit]  = start;
    w[div_pkg::ctrl_signed_bit] = sgn;
    w[div_pkg::ctrl_abort_bit]  = abort;
    return w;
  endfunction

  // setup phase, access phase sampled mid low clock, then idle
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #5;
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1) begin
      report_failure("pready low in the access phase");
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_access(1'b0, addr, 32'd0, data, err);
  endtask

  task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    if (err !== 1'b0) begin
      report_failure($sformatf("unexpected pslverr on write to offset %02h", addr));
    end
  endtask

  task automatic read_ok(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_read(addr, data, err);
    if (err !== 1'b0) begin
      report_failure($sformatf("unexpected pslverr on read of offset %02h", addr));
    end
  endtask

  task automatic wait_done(output logic [31:0] status);
    status = '0;
    while (status[1] !== 1'b1) begin
      read_ok(div_pkg::addr_status, status);
    end
  endtask

  task automatic run_division(input row_t r, input string tag);
    logic [31:0] status;
    logic [31:0] value;
    write_ok(div_pkg::addr_dividend, r.dividend);
    write_ok(div_pkg::addr_divisor, r.divisor);
    write_ok(div_pkg::addr_ctrl, ctrl_word(1'b1, r.is_signed, 1'b0));
    wait_done(status);
    if (status[2] !== r.reused) begin
      report_mismatch({tag, " reused"}, {31'd0, r.reused}, {31'd0, status[2]});
    end
    read_ok(div_pkg::addr_quotient, value);
    if (value !== r.quotient) begin
      report_mismatch({tag, " quotient"}, r.quotient, value);
    end
    read_ok(div_pkg::addr_remainder, value);
    if (value !== r.remainder) begin
      report_mismatch({tag, " remainder"}, r.remainder, value);
    end
  endtask

  // dividend, divisor, signed, quotient, remainder, reused
  task automatic fill_table();
    rows[0]  = {32'd100, 32'd7, 1'b0, 32'd14, 32'd2, 1'b0};
    rows[1]  = {32'd100, 32'd7, 1'b0, 32'd14, 32'd2, 1'b1};
    rows[2]  = {32'hFFFFFFFF, 32'd1, 1'b0, 32'hFFFFFFFF, 32'd0, 1'b0};
    rows[3]  = {32'hFFFFFFFF, 32'h10, 1'b0, 32'h0FFFFFFF, 32'hF, 1'b0};
    rows[4]  = {32'd1, 32'd3, 1'b0, 32'd0, 32'd1, 1'b0};
    rows[5]  = {32'd0, 32'd5, 1'b0, 32'd0, 32'd0, 1'b0};
    rows[6]  = {32'hFFFFFFF9, 32'd2, 1'b1, 32'hFFFFFFFD, 32'hFFFFFFFF, 1'b0};
    rows[7]  = {32'd7, 32'hFFFFFFFE, 1'b1, 32'hFFFFFFFD, 32'd1, 1'b0};
    rows[8]  = {32'hFFFFFFF9, 32'hFFFFFFFE, 1'b1, 32'd3, 32'hFFFFFFFF, 1'b0};
    rows[9]  = {32'd7, 32'd2, 1'b1, 32'd3, 32'd1, 1'b0};
    rows[10] = {32'd7, 32'd2, 1'b1, 32'd3, 32'd1, 1'b1};
    rows[11] = {32'h12345678, 32'd0, 1'b0, 32'hFFFFFFFF, 32'h12345678, 1'b0};
    rows[12] = {32'h80000001, 32'd0, 1'b1, 32'hFFFFFFFF, 32'h80000001, 1'b0};
    rows[13] = {32'h80000000, 32'hFFFFFFFF, 1'b1, 32'h80000000, 32'd0, 1'b0};
    rows[14] = {32'h80000000, 32'hFFFFFFFF, 1'b0, 32'd0, 32'h80000000, 1'b0};
    rows[15] = {32'h80000001, 32'h10, 1'b1, 32'hF8000001, 32'hFFFFFFF1, 1'b0};
    rows[16] = {32'd1000000, 32'd1000, 1'b0, 32'd1000, 32'd0, 1'b0};
  endtask

  initial begin
    logic [31:0] status;
    logic [31:0] value;
    logic        err;
    row_t        rnd;
    row_t        prev;
    void'($urandom(32'hc8425cad));
    clk         = 1'b0;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    error_count = 0;
    cycle_count = 0;
    fill_table();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < n_rows; i++) begin
      run_division(rows[i], $sformatf("row %0d", i));
    end

    prev = rows[n_rows-1];
    for (int i = 0; i < n_random; i++) begin
      rnd.dividend  = $urandom >> ($urandom % 32);
      rnd.divisor   = $urandom >> ($urandom % 32);
      if (rnd.divisor == 32'd0) begin
        rnd.divisor = 32'd1;
      end
      rnd.is_signed = 1'b0;
      rnd.quotient  = rnd.dividend / rnd.divisor;
      rnd.remainder = rnd.dividend % rnd.divisor;
      rnd.reused    = !prev.is_signed && rnd.dividend == prev.dividend &&
                      rnd.divisor == prev.divisor;
      run_division(rnd, $sformatf("random %0d", i));
      prev = rnd;
    end

    // abort a long division right after its start
    write_ok(div_pkg::addr_dividend, 32'hFFFFFFFF);
    write_ok(div_pkg::addr_divisor, 32'd3);
    write_ok(div_pkg::addr_ctrl, ctrl_word(1'b1, 1'b0, 1'b0));
    write_ok(div_pkg::addr_ctrl, ctrl_word(1'b0, 1'b0, 1'b1));
    read_ok(div_pkg::addr_status, status);
    if (status[1:0] !== 2'b00) begin
      report_mismatch("status busy/done after abort", 32'd0, {30'd0, status[1:0]});
    end
    run_division({32'hFFFFFFFF, 32'd3, 1'b0, 32'h55555555, 32'd0, 1'b0}, "after abort");

    // second start while the first result is unread
    write_ok(div_pkg::addr_dividend, 32'd50);
    write_ok(div_pkg::addr_divisor, 32'd5);
    write_ok(div_pkg::addr_ctrl, ctrl_word(1'b1, 1'b0, 1'b0));
    wait_done(status);
    apb_write(div_pkg::addr_ctrl, ctrl_word(1'b1, 1'b0, 1'b0), err);
    if (err !== 1'b1) begin
      report_failure("start with an unread result was accepted without pslverr");
    end
    read_ok(div_pkg::addr_status, status);
    if (status[1:0] !== 2'b11) begin
      report_mismatch("status busy/done while held", 32'd3, {30'd0, status[1:0]});
    end
    read_ok(div_pkg::addr_quotient, value);
    if (value !== 32'd10) begin
      report_mismatch("held quotient", 32'd10, value);
    end
    read_ok(div_pkg::addr_remainder, value);
    if (value !== 32'd0) begin
      report_mismatch("held remainder", 32'd0, value);
    end
    run_division({32'd91, 32'd10, 1'b0, 32'd9, 32'd1, 1'b0}, "after back-pressure");

    apb_read(8'h18, value, err);
    if (err !== 1'b1) begin
      report_failure("read of unmapped offset 18 gave no pslverr");
    end
    apb_write(8'hFC, 32'hA5A5A5A5, err);
    if (err !== 1'b1) begin
      report_failure("write to unmapped offset FC gave no pslverr");
    end

    $display("div_tb done, %0d errors", error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rtl/div_pkg.sv
rtl/div_clz.sv
rtl/div_apb_regs.sv
rtl/div_iter_unit.sv
rtl/div_result_buf.sv
rtl/div_top.sv
verification/div_properties.sv
verification/div_tb.sv
